/* run.sh */
#!/usr/bin/env bash
# compile and run the core testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

build_dir=build
log_file=sim.log

verilator --binary --timing -f src.f --top-module core_tb -Mdir "$build_dir" -o core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/core_sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\*\* TEST PASSED \*\*\*" "$log_file"; then
    exit 0
fi
echo "pass message not found in $log_file"
exit 1

/* source/core_pkg.sv */
/*
 * shared definitions for the rv32i integer core
 *   widths and register count
 *   wfi instruction word
 *   major opcode, alu function and error status enums
 *   decoded operation struct passed from decode to execute
 */

`default_nettype none

package core_pkg;

    // datapath and register file sizes
    localparam int xlen      = 32;
    localparam int reg_count = 32;
    localparam int reg_idx_w = 5;

    // the one system word the core accepts
    localparam logic [31:0] wfi_inst = 32'h1050_0073;

    // major opcodes of the kept instruction classes
    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_lui    = 7'b0110111,
        op_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and,
        alu_pass_b
    } alu_func_t;

    typedef enum logic [1:0] {
        no_error      = 2'd0,
        halted_on_wfi = 2'd1,
        illegal_inst  = 2'd2
    } error_status_t;

    // 76 bits, operands already resolved
    typedef struct packed {
        alu_func_t              alu_func;
        logic [xlen-1:0]        opa;
        logic [xlen-1:0]        opb;
        logic [reg_idx_w-1:0]   dest_idx;
        logic                   dest_wr;
        logic                   halt;
        logic                   illegal;
    } decoded_op_t;

endpackage

`default_nettype wire

/* source/core_top.sv */
/*
 * top level of the integer core
 *   handshake intake, decode, execute, result stages
 *   register file and the three stage interfaces
 */

`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_req,
    input  logic [31:0]                     inst,
    output logic                            inst_ack,
    output logic                            commit_valid,
    output logic                            commit_wr_en,
    output logic [core_pkg::reg_idx_w-1:0]  commit_wr_idx,
    output logic [core_pkg::xlen-1:0]       commit_wr_data,
    output core_pkg::error_status_t         error_status
);
    import core_pkg::*;

    logic                 stop;
    logic                 captured_valid;
    logic [31:0]          captured_inst;
    logic [reg_idx_w-1:0] rd_idx_a;
    logic [reg_idx_w-1:0] rd_idx_b;
    logic [xlen-1:0]      rd_data_a;
    logic [xlen-1:0]      rd_data_b;

    //////////////////////////////
    // stage interfaces
    //////////////////////////////
    dec_ex_if dec_ex_bus ();
    ex_res_if ex_res_bus ();
    wb_if     wb_bus ();

    inst_intake u_intake (
        .clock, .reset, .inst_req, .inst, .stop, .inst_ack,
        .captured_valid, .captured_inst
    );

    register_file u_regfile (
        .clock, .reset, .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .wb (wb_bus.sink)
    );

    // operands read here, bypass from writeback
    decode_stage u_decode (
        .clock, .reset, .captured_valid, .captured_inst,
        .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
        .wb (wb_bus.sink), .stop, .dec_ex (dec_ex_bus.source)
    );

    execute_stage u_execute (
        .clock, .reset, .dec_ex (dec_ex_bus.sink), .ex_res (ex_res_bus.source)
    );

    result_stage u_result (
        .clock, .reset, .ex_res (ex_res_bus.sink), .wb (wb_bus.source),
        .commit_valid, .commit_wr_en, .commit_wr_idx, .commit_wr_data,
        .error_status
    );

endmodule

`default_nettype wire

/* source/decode_stage.sv */
/*
 * instruction decode for the kept rv32i subset
 *   opcode and funct mapping onto alu functions
 *   i-type and u-type immediates, operand b select
 *   operand read with writeback bypass
 *   decode to execute pipeline register
 */

`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            captured_valid,
    input  logic [31:0]                     captured_inst,
    output logic [core_pkg::reg_idx_w-1:0]  rd_idx_a,
    output logic [core_pkg::reg_idx_w-1:0]  rd_idx_b,
    input  logic [core_pkg::xlen-1:0]       rd_data_a,
    input  logic [core_pkg::xlen-1:0]       rd_data_b,
    wb_if.sink                              wb,
    output logic                            stop,
    dec_ex_if.source                        dec_ex
);
    import core_pkg::*;

    opcode_t              opcode;
    logic [2:0]           funct3;
    logic [6:0]           funct7;
    logic [reg_idx_w-1:0] rd;
    logic [xlen-1:0]      imm_i;
    logic [xlen-1:0]      imm_u;
    logic [xlen-1:0]      opa_fwd;
    logic [xlen-1:0]      opb_fwd;
    alu_func_t            func;
    logic                 legal;
    logic                 writes;
    logic                 use_imm_i;
    logic                 use_imm_u;
    logic                 halt;
    decoded_op_t          dec_op;

    // alt picks sub over add and sra over srl
    function automatic alu_func_t map_func(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    //////////////////////////////
    // field extraction
    //////////////////////////////
    assign opcode   = opcode_t'(captured_inst[6:0]);
    assign rd       = captured_inst[11:7];
    assign funct3   = captured_inst[14:12];
    assign funct7   = captured_inst[31:25];
    assign rd_idx_a = captured_inst[19:15];
    assign rd_idx_b = captured_inst[24:20];
    assign imm_i    = {{20{captured_inst[31]}}, captured_inst[31:20]};
    assign imm_u    = {captured_inst[31:12], 12'b0};

    always_comb begin
        legal     = 1'b0;
        writes    = 1'b0;
        use_imm_i = 1'b0;
        use_imm_u = 1'b0;
        halt      = 1'b0;
        func      = map_func(funct3, 1'b0);
        case (opcode)
            op_reg: begin
                writes = 1'b1;
                func   = map_func(funct3, funct7[5]);
                legal  = (funct7 == 7'b0) ||
                         (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
            end
            op_imm: begin
                writes    = 1'b1;
                use_imm_i = 1'b1;
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0);
                end else if (funct3 == 3'b101) begin
                    // srai carries its alt bit in the immediate
                    func  = map_func(funct3, funct7[5]);
                    legal = (funct7 == 7'b0) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
            end
            op_lui: begin
                legal     = 1'b1;
                writes    = 1'b1;
                use_imm_u = 1'b1;
                func      = alu_pass_b;
            end
            op_system: begin
                // only wfi, every other system word traps
                legal = (captured_inst == wfi_inst);
                halt  = legal;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////
    // operands and bypass
    //////////////////////////////
    // producer in result stage has not reached the register file yet
    assign opa_fwd = (wb.wr_en && wb.idx == rd_idx_a && rd_idx_a != '0) ? wb.data : rd_data_a;
    assign opb_fwd = (wb.wr_en && wb.idx == rd_idx_b && rd_idx_b != '0) ? wb.data : rd_data_b;

    always_comb begin
        dec_op.alu_func = func;
        dec_op.opa      = opa_fwd;
        dec_op.opb      = use_imm_u ? imm_u : (use_imm_i ? imm_i : opb_fwd);
        dec_op.dest_idx = rd;
        // x0 writes still commit but never write
        dec_op.dest_wr  = writes && legal && (rd != '0);
        dec_op.halt     = halt;
        dec_op.illegal  = !legal;
    end

    // tells intake to stop acknowledging
    assign stop = captured_valid && (halt || !legal);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            dec_ex.valid <= 1'b0;
        end else begin
            dec_ex.valid <= captured_valid;
        end
    end

    always_ff @(posedge clock) begin
        if (captured_valid) begin
            dec_ex.op <= dec_op;
        end
    end

endmodule

`default_nettype wire

/* source/execute_stage.sv */
/*
 * integer alu and the execute to result register
 * shifts by the low five bits of operand b
 */

`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic       clock,
    input  logic       reset,
    dec_ex_if.sink     dec_ex,
    ex_res_if.source   ex_res
);
    import core_pkg::*;

    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [4:0]      shamt;
    logic [xlen-1:0] alu_out;

    assign a     = dec_ex.op.opa;
    assign b     = dec_ex.op.opb;
    assign shamt = b[4:0];

    always_comb begin
        case (dec_ex.op.alu_func)
            alu_add:  alu_out = a + b;
            alu_sub:  alu_out = a - b;
            alu_sll:  alu_out = a << shamt;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(a) < $signed(b)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, a < b};
            alu_xor:  alu_out = a ^ b;
            alu_srl:  alu_out = a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(a) >>> shamt);
            alu_or:   alu_out = a | b;
            alu_and:  alu_out = a & b;
            // lui passes the u immediate
            default:  alu_out = b;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_res.valid <= 1'b0;
        end else begin
            ex_res.valid <= dec_ex.valid;
        end
    end

    // control fields ride along with the result
    always_ff @(posedge clock) begin
        if (dec_ex.valid) begin
            ex_res.result   <= alu_out;
            ex_res.dest_idx <= dec_ex.op.dest_idx;
            ex_res.dest_wr  <= dec_ex.op.dest_wr;
            ex_res.halt     <= dec_ex.op.halt;
            ex_res.illegal  <= dec_ex.op.illegal;
        end
    end

endmodule

`default_nettype wire

/* source/inst_intake.sv */
/*
 * four-phase receive side of the instruction handshake
 * holds the accepted word and pulses captured_valid once
 * stop lock blocks any acknowledge after a halt or illegal word
 */

`timescale 1ns/1ps
`default_nettype none

module inst_intake (
    input  logic        clock,
    input  logic        reset,
    input  logic        inst_req,
    input  logic [31:0] inst,
    input  logic        stop,
    output logic        inst_ack,
    output logic        captured_valid,
    output logic [31:0] captured_inst
);
    logic stopped;
    logic accept;

    // new word only on req high with ack already low
    assign accept = inst_req && !inst_ack && !stopped;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            inst_ack       <= 1'b0;
            captured_valid <= 1'b0;
            stopped        <= 1'b0;
        end else begin
            captured_valid <= accept;
            if (accept) begin
                inst_ack <= 1'b1;
            end else if (!inst_req) begin
                // return to idle once the source lets go
                inst_ack <= 1'b0;
            end
            // sticky until reset
            if (stop) begin
                stopped <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            captured_inst <= inst;
        end
    end

endmodule

`default_nettype wire

/* source/pipe_ifs.sv */
/*
 * stage to stage interfaces of the core
 *   dec_ex_if   decoded operation into execute
 *   ex_res_if   alu result into the result stage
 *   wb_if       register writeback, also the bypass source
 */

`timescale 1ns/1ps
`default_nettype none

interface dec_ex_if;
    import core_pkg::*;
    logic        valid;
    decoded_op_t op;

    modport source (output valid, output op);
    modport sink   (input valid, input op);
endinterface

interface ex_res_if;
    import core_pkg::*;
    logic                 valid;
    logic [xlen-1:0]      result;
    logic [reg_idx_w-1:0] dest_idx;
    logic                 dest_wr;
    logic                 halt;
    logic                 illegal;

    modport source (output valid, output result, output dest_idx,
                    output dest_wr, output halt, output illegal);
    modport sink   (input valid, input result, input dest_idx,
                    input dest_wr, input halt, input illegal);
endinterface

interface wb_if;
    import core_pkg::*;
    logic                 wr_en;
    logic [reg_idx_w-1:0] idx;
    logic [xlen-1:0]      data;

    // register file and decode bypass both listen
    modport source (output wr_en, output idx, output data);
    modport sink   (input wr_en, input idx, input data);
endinterface

`default_nettype wire

/* source/register_file.sv */
/*
 * 32 entry architectural register file
 * two combinational read ports, one write port from writeback
 * x0 always reads zero
 */

`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                            clock,
    input  logic                            reset,
    input  logic [core_pkg::reg_idx_w-1:0]  rd_idx_a,
    input  logic [core_pkg::reg_idx_w-1:0]  rd_idx_b,
    output logic [core_pkg::xlen-1:0]       rd_data_a,
    output logic [core_pkg::xlen-1:0]       rd_data_b,
    wb_if.sink                              wb
);
    import core_pkg::*;

    // no storage behind x0
    logic [xlen-1:0] regs [1:reg_count-1];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.wr_en && (wb.idx != '0)) begin
            regs[wb.idx] <= wb.data;
        end
    end

    assign rd_data_a = (rd_idx_a == '0) ? '0 : regs[rd_idx_a];
    assign rd_data_b = (rd_idx_b == '0) ? '0 : regs[rd_idx_b];

endmodule

`default_nettype wire

/* source/result_stage.sv */
/*
 * commit reporting and writeback drive
 * illegal words raise the error status but do not commit
 * error status is sticky until reset
 */

`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                            clock,
    input  logic                            reset,
    ex_res_if.sink                          ex_res,
    wb_if.source                            wb,
    output logic                            commit_valid,
    output logic                            commit_wr_en,
    output logic [core_pkg::reg_idx_w-1:0]  commit_wr_idx,
    output logic [core_pkg::xlen-1:0]       commit_wr_data,
    output core_pkg::error_status_t         error_status
);
    import core_pkg::*;

    error_status_t err_q;
    error_status_t err_now;

    // commit view of the registered result
    assign commit_valid   = ex_res.valid && !ex_res.illegal;
    assign commit_wr_en   = commit_valid && ex_res.dest_wr;
    assign commit_wr_idx  = ex_res.dest_idx;
    assign commit_wr_data = ex_res.result;

    // register file takes this at the next edge
    assign wb.wr_en = commit_wr_en;
    assign wb.idx   = ex_res.dest_idx;
    assign wb.data  = ex_res.result;

    always_comb begin
        err_now = no_error;
        if (ex_res.valid && ex_res.illegal) begin
            err_now = illegal_inst;
        end else if (ex_res.valid && ex_res.halt) begin
            err_now = halted_on_wfi;
        end
    end

    // first stopping instruction wins
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            err_q <= no_error;
        end else if (err_q == no_error) begin
            err_q <= err_now;
        end
    end

    // status shows in the same cycle as the stopping commit
    assign error_status = (err_q != no_error) ? err_q : err_now;

endmodule

`default_nettype wire

/* src.f */
source/core_pkg.sv
source/pipe_ifs.sv
source/inst_intake.sv
source/register_file.sv
source/decode_stage.sv
source/execute_stage.sv
source/result_stage.sv
source/core_top.sv
tests/core_checker.sv
tests/core_tb.sv

/* tests/core_checker.sv */
/*
 * commit checker for the integer core
 *   model register file and rv32i subset decode
 *   queue of expected commits with their due cycle
 *   four-phase acknowledge rule and error status checks
 */

`timescale 1ns/1ps
`default_nettype none

module core_checker (
    input  logic                            clock,
    input  logic                            reset,
    input  logic                            inst_req,
    input  logic [31:0]                     inst,
    input  logic                            inst_ack,
    input  logic                            commit_valid,
    input  logic                            commit_wr_en,
    input  logic [core_pkg::reg_idx_w-1:0]  commit_wr_idx,
    input  logic [core_pkg::xlen-1:0]       commit_wr_data,
    input  core_pkg::error_status_t         error_status,
    input  logic                            check_point,
    input  logic [1:0]                      run_id,
    output int                              mismatch_count,
    output int                              protocol_count,
    output int                              commit_count
);
    import core_pkg::*;

    localparam logic [31:0] wfi_word = 32'h1050_0073;
    localparam logic [1:0]  kind_alu = 2'd0;
    localparam logic [1:0]  kind_wfi = 2'd1;
    localparam logic [1:0]  kind_bad = 2'd2;

    typedef struct packed {
        logic [31:0]     due;
        logic [1:0]      kind;
        logic            wr;
        logic [4:0]      idx;
        logic [xlen-1:0] data;
    } expect_t;

    expect_t         pending [$];
    logic [xlen-1:0] model_regs [0:31];
    logic [31:0]     cycle = '0;
    logic            stopped = 1'b0;
    logic            prev_ack = 1'b0;
    logic            prev_req = 1'b0;
    logic [31:0]     prev_inst = '0;
    error_status_t   final_status = no_error;
    int              mismatches = 0;
    int              violations = 0;
    int              commits = 0;

    assign mismatch_count = mismatches;
    assign protocol_count = violations;
    assign commit_count   = commits;

    function automatic string run_name();
        return (run_id == 2'd1) ? "random_alu" : "illegal_stop";
    endfunction

    // rv32i alu semantics, alt selects sub and sra
    function automatic logic [xlen-1:0] alu_model(input logic [2:0] f3, input logic alt,
                                                  input logic [xlen-1:0] a,
                                                  input logic [xlen-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << sh;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? $unsigned($signed(a) >>> sh) : a >> sh;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic compare_value(input string field, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            mismatches++;
            $display("Mismatch %s %s: expected %h, actual %h", run_name(), field, exp, act);
        end
    endtask

    //////////////////////////////
    // model of one accepted word
    //////////////////////////////
    task automatic predict(input logic [31:0] word, input logic [31:0] due);
        expect_t         e;
        logic [6:0]      opc;
        logic [2:0]      f3;
        logic [6:0]      f7;
        logic [4:0]      rd;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] imm;
        logic            legal;
        opc    = word[6:0];
        rd     = word[11:7];
        f3     = word[14:12];
        f7     = word[31:25];
        a      = model_regs[word[19:15]];
        b      = model_regs[word[24:20]];
        imm    = {{20{word[31]}}, word[31:20]};
        e.due  = due;
        e.kind = kind_alu;
        e.wr   = (rd != 5'd0);
        e.idx  = rd;
        e.data = '0;
        legal  = 1'b1;
        if (opc == op_reg) begin
            legal  = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            e.data = alu_model(f3, f7[5], a, b);
        end else if (opc == op_imm) begin
            if (f3 == 3'd1) begin
                legal = (f7 == 7'h00);
            end else if (f3 == 3'd5) begin
                legal = (f7 == 7'h00) || (f7 == 7'h20);
            end
            // only the shift right form takes an alt bit from the immediate
            e.data = alu_model(f3, (f3 == 3'd5) && f7[5], a, imm);
        end else if (opc == op_lui) begin
            e.data = {word[31:12], 12'b0};
        end else if (word == wfi_word) begin
            e.kind       = kind_wfi;
            e.wr         = 1'b0;
            final_status = halted_on_wfi;
        end else begin
            legal = 1'b0;
        end
        if (!legal) begin
            e.kind       = kind_bad;
            e.wr         = 1'b0;
            final_status = illegal_inst;
        end
        if (e.wr) begin
            model_regs[rd] = e.data;
        end
        if (e.kind != kind_alu) begin
            stopped = 1'b1;
        end
        pending.push_back(e);
    endtask

    task automatic check_commit(input expect_t e);
        if (e.kind == kind_bad) begin
            // illegal word never commits
            if (commit_valid) begin
                violations++;
                $display("illegal word committed at cycle %0d", cycle);
            end
            compare_value("error_status", 32'(illegal_inst), 32'(error_status));
        end else if (!commit_valid) begin
            violations++;
            $display("no commit at cycle %0d, two cycles after the acknowledge", cycle);
        end else begin
            commits++;
            compare_value("commit_wr_en", 32'(e.wr), 32'(commit_wr_en));
            compare_value("commit_wr_idx", 32'(e.idx), 32'(commit_wr_idx));
            if (e.kind == kind_wfi) begin
                compare_value("error_status", 32'(halted_on_wfi), 32'(error_status));
            end else begin
                compare_value("commit_wr_data", e.data, commit_wr_data);
                compare_value("error_status", 32'(no_error), 32'(error_status));
            end
        end
    endtask

    //////////////////////////////
    // sampling at the falling edge
    //////////////////////////////
    always @(negedge clock) begin : watch
        logic    exp_ack;
        expect_t head;
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            pending.delete();
            stopped      = 1'b0;
            final_status = no_error;
            cycle        = '0;
        end else begin
            cycle = cycle + 32'd1;
            // ack follows req one edge later, new accepts blocked once stopped
            exp_ack = prev_ack ? prev_req : (prev_req && !stopped);
            if (inst_ack !== exp_ack) begin
                violations++;
                $display("inst_ack is %b at cycle %0d, the four-phase rule gives %b",
                         inst_ack, cycle, exp_ack);
            end
            if (inst_ack && !prev_ack) begin
                predict(prev_inst, cycle + 32'd2);
            end
            if (pending.size() > 0 && pending[0].due == cycle) begin
                head = pending.pop_front();
                check_commit(head);
            end else if (commit_valid) begin
                violations++;
                $display("commit_valid high at cycle %0d with no commit due", cycle);
            end
            if (check_point) begin
                if (pending.size() != 0) begin
                    violations++;
                    $display("%0d commits still outstanding at end of run", pending.size());
                end
                compare_value("final error_status", 32'(final_status), 32'(error_status));
            end
        end
        prev_ack  = inst_ack;
        prev_req  = inst_req;
        prev_inst = inst;
    end

endmodule

`default_nettype wire

/* tests/core_tb.sv */
/*
 * testbench for the integer core
 *   clock, reset and lcg instruction stimulus
 *   four-phase source, random run ending in wfi
 *   short directed run ending in an illegal word
 *   watchdog and the closing report
 */

`timescale 1ns/1ps
`default_nettype none

module core_tb;
    import core_pkg::*;

    localparam int          period          = 40;
    localparam int          drive_delay     = 2;
    localparam int          num_random      = 300;
    localparam int          num_directed    = 5;
    localparam int          ack_limit       = 20;
    localparam int          watchdog_cycles = (num_random + num_directed + 3) * 8 + 100;
    localparam logic [31:0] seed            = 32'd75;
    localparam logic [31:0] wfi_word        = 32'h1050_0073;

    logic                 clock;
    logic                 reset;
    logic                 inst_req;
    logic [31:0]          inst;
    logic                 inst_ack;
    logic                 commit_valid;
    logic                 commit_wr_en;
    logic [reg_idx_w-1:0] commit_wr_idx;
    logic [xlen-1:0]      commit_wr_data;
    error_status_t        error_status;
    logic                 check_point;
    logic [1:0]           run_id;
    int                   mismatch_count;
    int                   protocol_count;
    int                   commit_count;
    int                   source_errors;
    logic [31:0]          lcg_state;
    logic [4:0]           last_rd;

    core_top u_dut (
        .clock, .reset, .inst_req, .inst, .inst_ack,
        .commit_valid, .commit_wr_en, .commit_wr_idx, .commit_wr_data, .error_status
    );

    core_checker u_checker (
        .clock, .reset, .inst_req, .inst, .inst_ack,
        .commit_valid, .commit_wr_en, .commit_wr_idx, .commit_wr_data, .error_status,
        .check_point, .run_id, .mismatch_count, .protocol_count, .commit_count
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // dest mostly in x0..x7, sources often the previous dest
    function automatic logic [31:0] random_word();
        logic [31:0] r;
        logic [31:0] s;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = next_random();
        s   = next_random();
        rd  = (r[31:30] == 2'b11) ? s[31:27] : {2'b00, s[26:24]};
        rs1 = r[29] ? last_rd : {2'b00, s[23:21]};
        rs2 = r[28] ? last_rd : {2'b00, s[20:18]};
        f3  = r[27:25];
        f7  = (r[24] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
        last_rd = rd;
        case (r[23:22])
            2'd0, 2'd1: return {f7, rs2, rs1, f3, rd, op_reg};
            2'd2: begin
                // shift immediates keep the funct7 field
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {f7, rs2, rs1, f3, rd, op_imm};
                end
                return {s[17:6], rs1, f3, rd, op_imm};
            end
            default: return {s[5:0], r[21:8], rd, op_lui};
        endcase
    endfunction

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            #drive_delay;
        end
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        idle(4);
        reset = 1'b0;
        idle(1);
    endtask

    //////////////////////////////
    // four-phase source
    //////////////////////////////
    task automatic send_word(input logic [31:0] word, input int gap);
        int waited;
        idle(gap);
        inst     = word;
        inst_req = 1'b1;
        waited   = 0;
        do begin
            @(posedge clock);
            #drive_delay;
            waited++;
        end while (!inst_ack && waited < ack_limit);
        if (!inst_ack) begin
            source_errors++;
            $display("no inst_ack for word %h after %0d cycles", word, waited);
        end
        inst_req = 1'b0;
        while (inst_ack) begin
            @(posedge clock);
            #drive_delay;
        end
    endtask

    // a stopped core must leave this request unanswered
    task automatic expect_no_ack(input logic [31:0] word, input int cycles);
        inst     = word;
        inst_req = 1'b1;
        repeat (cycles) begin
            @(posedge clock);
            #drive_delay;
            if (inst_ack) begin
                source_errors++;
                $display("inst_ack came for word %h after the core stopped", word);
            end
        end
        inst_req = 1'b0;
        idle(2);
    endtask

    task automatic end_of_run();
        idle(4);
        check_point = 1'b1;
        idle(1);
        check_point = 1'b0;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        int          total;
        reset         = 1'b1;
        inst_req      = 1'b0;
        inst          = '0;
        check_point   = 1'b0;
        run_id        = 2'd1;
        source_errors = 0;
        lcg_state     = seed;
        last_rd       = 5'd0;
        apply_reset();

        // random alu run, halted by wfi
        for (int i = 0; i < num_random; i++) begin
            r = next_random();
            send_word(random_word(), int'(r[31:30]));
        end
        send_word(wfi_word, 0);
        expect_no_ack(random_word(), 6);
        end_of_run();

        // directed run, back to back bypass then an illegal word
        run_id = 2'd2;
        apply_reset();
        send_word({12'd5, 5'd0, 3'd0, 5'd1, op_imm}, 0);
        send_word({7'h00, 5'd1, 5'd1, 3'd0, 5'd2, op_reg}, 0);
        send_word({7'h00, 5'd1, 5'd2, 3'd0, 5'd0, op_reg}, 0);
        send_word({7'h00, 5'd2, 5'd0, 3'd6, 5'd3, op_reg}, 0);
        send_word(32'hffff_ffff, 1);
        expect_no_ack({12'd7, 5'd0, 3'd0, 5'd4, op_imm}, 6);
        end_of_run();

        total = mismatch_count + protocol_count + source_errors;
        $display("errors: %0d mismatches, %0d protocol, %0d source, %0d commits checked",
                 mismatch_count, protocol_count, source_errors, commit_count);
        if (total == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // bound from the instruction count of both runs
    initial begin
        #(watchdog_cycles * period);
        $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
